/* common/isaPkg.sv */
`default_nettype none

package isaPkg;

   // Data word and instruction word share one width
   localparam int DataWidth = 16;

   // Eight architectural registers
   localparam int RegAddrWidth = 3;

   // Instruction layout
   //   [15:12] opcode
   //   [11:9]  rd
   //   [8:6]   rs
   //   [5:3]   rt
   //   [5:0]   imm6, sign extended
   //   [8:0]   imm9, sign extended
   localparam int OpcodeWidth = 4;
   localparam int OpcodeLsb = 12;
   localparam int RdLsb = 9;
   localparam int RsLsb = 6;
   localparam int RtLsb = 3;
   localparam int Imm6Width = 6;
   localparam int Imm9Width = 9;

   // An all-zero word decodes as HALT
   typedef enum logic [OpcodeWidth-1:0] {
      OpHalt = 4'h0,
      OpAdd  = 4'h1,
      OpSub  = 4'h2,
      OpAnd  = 4'h3,
      OpXor  = 4'h4,
      OpAddi = 4'h5,
      OpLbi  = 4'h6,
      OpLd   = 4'h7,
      OpSt   = 4'h8,
      OpBeqz = 4'h9
   } opcodeT;

   typedef enum logic [1:0] {
      AluAdd = 2'd0,
      AluSub = 2'd1,
      AluAnd = 2'd2,
      AluXor = 2'd3
   } aluOpT;

endpackage

`default_nettype wire

/* common/pipePkg.sv */
`default_nettype none

package pipePkg;

   // Decode to execute
   typedef struct packed {
      logic                                valid;
      isaPkg::aluOpT                       aluOp;
      isaPkg::opcodeT                      opcode;
      logic [isaPkg::DataWidth-1:0]        opA;
      logic [isaPkg::DataWidth-1:0]        opB;
      logic [isaPkg::DataWidth-1:0]        storeData;
      logic [isaPkg::DataWidth-1:0]        imm;
      logic [isaPkg::DataWidth-1:0]        pcNext;
      logic [isaPkg::RegAddrWidth-1:0]     wrReg;
      logic                                regWrite;
   } dxPayloadT;

   // Execute to memory
   // result is the ALU value, or the data address for LD and ST
   typedef struct packed {
      logic                                valid;
      logic [isaPkg::DataWidth-1:0]        result;
      logic [isaPkg::DataWidth-1:0]        storeData;
      logic                                memRead;
      logic                                memWrite;
      logic [isaPkg::RegAddrWidth-1:0]     wrReg;
      logic                                regWrite;
      logic                                halt;
      logic                                illegal;
   } xmPayloadT;

   // Memory to writeback
   typedef struct packed {
      logic                                valid;
      logic [isaPkg::DataWidth-1:0]        wbData;
      logic [isaPkg::RegAddrWidth-1:0]     wrReg;
      logic                                regWrite;
      logic                                halt;
      logic                                illegal;
   } mwPayloadT;

endpackage

`default_nettype wire

/* rtl/pipeReg.sv */
`default_nettype none

module pipeReg #(
   parameter type payloadT = logic
) (
   input  wire logic clk,
   input  wire logic arstN,
   input  wire logic hold,
   input  wire logic flush,
   input  wire payloadT d,
   output payloadT   q
);

   // An all-zero payload is a bubble
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         q <= '0;
      end else if (flush) begin
         q <= '0;
      end else if (!hold) begin
         q <= d;
      end
   end

endmodule

`default_nettype wire

/* proc/fetch.sv */
`default_nettype none

module fetch (
   input  wire logic                         clk,
   input  wire logic                         arstN,
   input  wire logic [isaPkg::DataWidth-1:0] instr,
   input  wire logic                         stall,
   input  wire logic                         haltStop,
   input  wire logic                         redirect,
   input  wire logic [isaPkg::DataWidth-1:0] redirectPc,
   output logic [isaPkg::DataWidth-1:0]      instrAddr,
   output logic [isaPkg::DataWidth-1:0]      instrD,
   output logic [isaPkg::DataWidth-1:0]      pcNextD,
   output logic                              validD
);

   logic [isaPkg::DataWidth-1:0] pc;
   logic                         stopped;

   assign instrAddr = pc;

   // Once a HALT is in decode nothing more is fetched
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         pc      <= '0;
         stopped <= 1'b0;
      end else if (redirect) begin
         pc <= redirectPc;
      end else if (haltStop) begin
         stopped <= 1'b1;
      end else if (!stall && !stopped) begin
         pc <= pc + 1'b1;
      end
   end

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         validD <= 1'b0;
      end else if (redirect || haltStop || stopped) begin
         validD <= 1'b0;
      end else if (!stall) begin
         validD <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (!stall) begin
         instrD  <= instr;
         pcNextD <= pc + 1'b1;
      end
   end

endmodule

`default_nettype wire

/* proc/decode.sv */
`default_nettype none

module decode (
   input  wire logic [isaPkg::DataWidth-1:0]    instrD,
   input  wire logic [isaPkg::DataWidth-1:0]    pcNextD,
   input  wire logic                            validD,
   input  wire logic [isaPkg::DataWidth-1:0]    rdDataA,
   input  wire logic [isaPkg::DataWidth-1:0]    rdDataB,
   input  wire logic [isaPkg::RegAddrWidth-1:0] xWrReg,
   input  wire logic                            xRegWrite,
   input  wire logic [isaPkg::RegAddrWidth-1:0] mWrReg,
   input  wire logic                            mRegWrite,
   input  wire logic                            redirect,
   output logic [isaPkg::RegAddrWidth-1:0]      rdAddrA,
   output logic [isaPkg::RegAddrWidth-1:0]      rdAddrB,
   output logic                                 stall,
   output logic                                 haltStop,
   output pipePkg::dxPayloadT                   dxOut
);

   localparam int Width = isaPkg::DataWidth;

   isaPkg::opcodeT                  opcode;
   logic [isaPkg::RegAddrWidth-1:0] rd;
   logic [isaPkg::RegAddrWidth-1:0] rs;
   logic [isaPkg::RegAddrWidth-1:0] rt;
   logic [Width-1:0]                imm6;
   logic [Width-1:0]                imm9;
   logic                            useA;
   logic                            useB;
   logic                            isStop;
   logic                            hitA;
   logic                            hitB;
   pipePkg::dxPayloadT              payload;

   assign opcode = isaPkg::opcodeT'(instrD[isaPkg::OpcodeLsb +: isaPkg::OpcodeWidth]);
   assign rd = instrD[isaPkg::RdLsb +: isaPkg::RegAddrWidth];
   assign rs = instrD[isaPkg::RsLsb +: isaPkg::RegAddrWidth];
   assign rt = instrD[isaPkg::RtLsb +: isaPkg::RegAddrWidth];

   assign imm6 = {{(Width - isaPkg::Imm6Width){instrD[isaPkg::Imm6Width-1]}},
                  instrD[isaPkg::Imm6Width-1:0]};
   assign imm9 = {{(Width - isaPkg::Imm9Width){instrD[isaPkg::Imm9Width-1]}},
                  instrD[isaPkg::Imm9Width-1:0]};

   // ST reads the register named in the rd field as its data
   assign rdAddrA = rs;
   assign rdAddrB = (opcode == isaPkg::OpSt) ? rd : rt;

   always_comb begin
      payload           = '0;
      payload.valid     = 1'b1;
      payload.opcode    = opcode;
      payload.opA       = rdDataA;
      payload.opB       = rdDataB;
      payload.storeData = rdDataB;
      payload.imm       = imm6;
      payload.pcNext    = pcNextD;
      payload.wrReg     = rd;
      useA              = 1'b0;
      useB              = 1'b0;
      isStop            = 1'b0;

      case (opcode)
         isaPkg::OpSub: payload.aluOp = isaPkg::AluSub;
         isaPkg::OpAnd: payload.aluOp = isaPkg::AluAnd;
         isaPkg::OpXor: payload.aluOp = isaPkg::AluXor;
         default:       payload.aluOp = isaPkg::AluAdd;
      endcase

      case (opcode)
         isaPkg::OpAdd, isaPkg::OpSub, isaPkg::OpAnd, isaPkg::OpXor: begin
            useA             = 1'b1;
            useB             = 1'b1;
            payload.regWrite = 1'b1;
         end
         isaPkg::OpAddi, isaPkg::OpLd: begin
            useA             = 1'b1;
            payload.opB      = imm6;
            payload.regWrite = 1'b1;
         end
         isaPkg::OpLbi: begin
            payload.opA      = '0;
            payload.opB      = imm9;
            payload.regWrite = 1'b1;
         end
         isaPkg::OpSt: begin
            useA        = 1'b1;
            useB        = 1'b1;
            payload.opB = imm6;
         end
         isaPkg::OpBeqz: useA = 1'b1;
         // HALT and illegal words both stop the front end
         default: isStop = 1'b1;
      endcase
   end

   // Writers in execute or memory block the read, writeback is bypassed
   assign hitA = (xRegWrite && xWrReg == rdAddrA) || (mRegWrite && mWrReg == rdAddrA);
   assign hitB = (xRegWrite && xWrReg == rdAddrB) || (mRegWrite && mWrReg == rdAddrB);

   assign stall    = validD && ((useA && hitA) || (useB && hitB));
   assign haltStop = validD && isStop && !redirect;
   assign dxOut    = (validD && !stall) ? payload : '0;

endmodule

`default_nettype wire

/* proc/regFile.sv */
`default_nettype none

module regFile (
   input  wire logic                            clk,
   input  wire logic                            arstN,
   input  wire logic [isaPkg::RegAddrWidth-1:0] rdAddrA,
   input  wire logic [isaPkg::RegAddrWidth-1:0] rdAddrB,
   input  wire logic                            wrEn,
   input  wire logic [isaPkg::RegAddrWidth-1:0] wrAddr,
   input  wire logic [isaPkg::DataWidth-1:0]    wrData,
   output logic [isaPkg::DataWidth-1:0]         rdDataA,
   output logic [isaPkg::DataWidth-1:0]         rdDataB
);

   localparam int NumRegs = 2 ** isaPkg::RegAddrWidth;

   logic [isaPkg::DataWidth-1:0] regs [NumRegs];

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         for (int i = 0; i < NumRegs; i++) begin
            regs[i] <= '0;
         end
      end else if (wrEn) begin
         regs[wrAddr] <= wrData;
      end
   end

   // Writeback value is visible to decode in the same cycle
   assign rdDataA = (wrEn && wrAddr == rdAddrA) ? wrData : regs[rdAddrA];
   assign rdDataB = (wrEn && wrAddr == rdAddrB) ? wrData : regs[rdAddrB];

endmodule

`default_nettype wire

/* proc/execute.sv */
`default_nettype none

module execute (
   input  wire pipePkg::dxPayloadT              dxIn,
   output pipePkg::xmPayloadT                   xmOut,
   output logic                                 redirect,
   output logic [isaPkg::DataWidth-1:0]         redirectPc,
   output logic [isaPkg::RegAddrWidth-1:0]      xWrReg,
   output logic                                 xRegWrite
);

   logic [isaPkg::DataWidth-1:0] aluOut;
   logic                         isLoad;
   logic                         isStore;
   logic                         isBranch;
   logic                         isHalt;
   logic                         isIllegal;

   always_comb begin
      case (dxIn.aluOp)
         isaPkg::AluAdd: aluOut = dxIn.opA + dxIn.opB;
         isaPkg::AluSub: aluOut = dxIn.opA - dxIn.opB;
         isaPkg::AluAnd: aluOut = dxIn.opA & dxIn.opB;
         isaPkg::AluXor: aluOut = dxIn.opA ^ dxIn.opB;
      endcase
   end

   always_comb begin
      isLoad    = 1'b0;
      isStore   = 1'b0;
      isBranch  = 1'b0;
      isHalt    = 1'b0;
      isIllegal = 1'b0;
      case (dxIn.opcode)
         isaPkg::OpLd:   isLoad = 1'b1;
         isaPkg::OpSt:   isStore = 1'b1;
         isaPkg::OpBeqz: isBranch = 1'b1;
         isaPkg::OpHalt: isHalt = 1'b1;
         isaPkg::OpAdd, isaPkg::OpSub, isaPkg::OpAnd, isaPkg::OpXor,
         isaPkg::OpAddi, isaPkg::OpLbi: ;
         default:        isIllegal = 1'b1;
      endcase
   end

   // Target is relative to the word after the branch
   assign redirect   = dxIn.valid && isBranch && (dxIn.opA == '0);
   assign redirectPc = dxIn.pcNext + dxIn.imm;

   assign xWrReg    = dxIn.wrReg;
   assign xRegWrite = dxIn.valid && dxIn.regWrite;

   always_comb begin
      xmOut.valid     = dxIn.valid;
      xmOut.result    = aluOut;
      xmOut.storeData = dxIn.storeData;
      xmOut.memRead   = dxIn.valid && isLoad;
      xmOut.memWrite  = dxIn.valid && isStore;
      xmOut.wrReg     = dxIn.wrReg;
      xmOut.regWrite  = xRegWrite;
      xmOut.halt      = dxIn.valid && isHalt;
      xmOut.illegal   = dxIn.valid && isIllegal;
   end

endmodule

`default_nettype wire

/* proc/dataMem.sv */
`default_nettype none

module dataMem #(
   parameter int DataMemAddrWidth = 8
) (
   input  wire logic               clk,
   input  wire logic               arstN,
   input  wire pipePkg::xmPayloadT xmIn,
   input  wire pipePkg::mwPayloadT mwIn,
   output pipePkg::mwPayloadT      mwOut,
   output logic                    halted,
   output logic                    err
);

   logic [isaPkg::DataWidth-1:0] mem [2 ** DataMemAddrWidth];
   logic [DataMemAddrWidth-1:0]  addr;

   // Word address, upper address bits are ignored
   assign addr = xmIn.result[DataMemAddrWidth-1:0];

   always_ff @(posedge clk) begin
      if (xmIn.memWrite) begin
         mem[addr] <= xmIn.storeData;
      end
   end

   always_comb begin
      mwOut.valid    = xmIn.valid;
      mwOut.wbData   = xmIn.memRead ? mem[addr] : xmIn.result;
      mwOut.wrReg    = xmIn.wrReg;
      mwOut.regWrite = xmIn.regWrite;
      mwOut.halt     = xmIn.halt;
      mwOut.illegal  = xmIn.illegal;
   end

   // Sticky until reset, taken from the writeback stage
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         halted <= 1'b0;
         err    <= 1'b0;
      end else if (mwIn.valid) begin
         halted <= halted | mwIn.halt | mwIn.illegal;
         err    <= err | mwIn.illegal;
      end
   end

endmodule

`default_nettype wire

/* proc/proc.sv */
`default_nettype none

module proc #(
   parameter int DataMemAddrWidth = 8
) (
   input  wire logic                         clk,
   input  wire logic                         arstN,
   input  wire logic [isaPkg::DataWidth-1:0] instr,
   output logic [isaPkg::DataWidth-1:0]      instrAddr,
   output logic                              wbEn,
   output logic [isaPkg::RegAddrWidth-1:0]   wbReg,
   output logic [isaPkg::DataWidth-1:0]      wbData,
   output logic                              halted,
   output logic                              err
);

   // Fetch to decode
   logic [isaPkg::DataWidth-1:0]    instrD;
   logic [isaPkg::DataWidth-1:0]    pcNextD;
   logic                            validD;

   // Control between stages
   logic                            stall;
   logic                            haltStop;
   logic                            redirect;
   logic [isaPkg::DataWidth-1:0]    redirectPc;
   logic [isaPkg::RegAddrWidth-1:0] xWrReg;
   logic                            xRegWrite;

   // Register file read side
   logic [isaPkg::RegAddrWidth-1:0] rdAddrA;
   logic [isaPkg::RegAddrWidth-1:0] rdAddrB;
   logic [isaPkg::DataWidth-1:0]    rdDataA;
   logic [isaPkg::DataWidth-1:0]    rdDataB;

   pipePkg::dxPayloadT              dxD;
   pipePkg::dxPayloadT              dxQ;
   pipePkg::xmPayloadT              xmD;
   pipePkg::xmPayloadT              xmQ;
   pipePkg::mwPayloadT              mwD;
   pipePkg::mwPayloadT              mwQ;

   fetch fetchStage (
      .clk(clk), .arstN(arstN), .instr(instr), .stall(stall), .haltStop(haltStop),
      .redirect(redirect), .redirectPc(redirectPc), .instrAddr(instrAddr),
      .instrD(instrD), .pcNextD(pcNextD), .validD(validD)
   );

   decode decodeStage (
      .instrD(instrD), .pcNextD(pcNextD), .validD(validD),
      .rdDataA(rdDataA), .rdDataB(rdDataB),
      .xWrReg(xWrReg), .xRegWrite(xRegWrite),
      .mWrReg(xmQ.wrReg), .mRegWrite(xmQ.valid && xmQ.regWrite),
      .redirect(redirect), .rdAddrA(rdAddrA), .rdAddrB(rdAddrB),
      .stall(stall), .haltStop(haltStop), .dxOut(dxD)
   );

   regFile regs (
      .clk(clk), .arstN(arstN), .rdAddrA(rdAddrA), .rdAddrB(rdAddrB),
      .wrEn(wbEn), .wrAddr(wbReg), .wrData(wbData),
      .rdDataA(rdDataA), .rdDataB(rdDataB)
   );

   // A taken branch kills the instruction in decode
   pipeReg #(.payloadT(pipePkg::dxPayloadT)) decode2exec (
      .clk(clk), .arstN(arstN), .hold(1'b0), .flush(redirect), .d(dxD), .q(dxQ)
   );

   execute executeStage (
      .dxIn(dxQ), .xmOut(xmD), .redirect(redirect), .redirectPc(redirectPc),
      .xWrReg(xWrReg), .xRegWrite(xRegWrite)
   );

   pipeReg #(.payloadT(pipePkg::xmPayloadT)) exec2mem (
      .clk(clk), .arstN(arstN), .hold(1'b0), .flush(1'b0), .d(xmD), .q(xmQ)
   );

   dataMem #(.DataMemAddrWidth(DataMemAddrWidth)) memStage (
      .clk(clk), .arstN(arstN), .xmIn(xmQ), .mwIn(mwQ),
      .mwOut(mwD), .halted(halted), .err(err)
   );

   pipeReg #(.payloadT(pipePkg::mwPayloadT)) mem2wb (
      .clk(clk), .arstN(arstN), .hold(1'b0), .flush(1'b0), .d(mwD), .q(mwQ)
   );

   assign wbEn   = mwQ.valid && mwQ.regWrite;
   assign wbReg  = mwQ.wrReg;
   assign wbData = mwQ.wbData;

endmodule

`default_nettype wire

/* tests/proc_assertions.sv */
`default_nettype none

module procAssertions (
   input wire logic clk,
   input wire logic arstN,
   input wire logic wbEn,
   input wire logic halted,
   input wire logic err
);

   // Nothing retires once the core has stopped
   assert property (@(posedge clk) disable iff (!arstN) halted |-> !wbEn)
      else $error("register write seen while halted");

   // An illegal opcode always stops the core
   assert property (@(posedge clk) disable iff (!arstN) err |-> halted)
      else $error("err is high but halted is low");

   assert property (@(posedge clk) disable iff (!arstN) !$fell(halted))
      else $error("halted fell without a reset");

endmodule

`default_nettype wire

/* tests/procTb.sv */
`default_nettype none

module procTb;

   localparam int NumProgs = 5;
   localparam int MaxLen = 16;
   localparam int MaxEvents = 16;
   localparam int RomDepth = 16;
   localparam logic [31:0] Seed = 32'h36a1_9b85;

   logic        clk;
   logic        arstN;
   logic [15:0] instr;
   logic [15:0] instrAddr;
   logic        wbEn;
   logic [2:0]  wbReg;
   logic [15:0] wbData;
   logic        halted;
   logic        err;

   logic [15:0] rom [RomDepth];

   // Program table with hand-computed writeback events
   logic [15:0] progWords [NumProgs][MaxLen];
   int          progLen [NumProgs];
   logic [2:0]  expReg [NumProgs][MaxEvents];
   logic [15:0] expData [NumProgs][MaxEvents];
   int          expCount [NumProgs];
   bit          expErr [NumProgs];

   int cycles;
   int cycleLimit;

   proc #(.DataMemAddrWidth(8)) dut (
      .clk(clk), .arstN(arstN), .instr(instr), .instrAddr(instrAddr),
      .wbEn(wbEn), .wbReg(wbReg), .wbData(wbData), .halted(halted), .err(err)
   );

   bind proc procAssertions assertChecks (
      .clk(clk), .arstN(arstN), .wbEn(wbEn), .halted(halted), .err(err)
   );

   // HALT words past the end of the ROM
   assign instr = (instrAddr < 16'(RomDepth)) ? rom[instrAddr[3:0]] : '0;

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   task automatic abortRun(input string why);
      $display("%s", why);
      $display("SOME TESTS FAILED");
      $fatal(1, "run stopped");
   endtask

   task automatic reportMismatch(input string sig, input logic [15:0] expv,
                                 input logic [15:0] actv);
      abortRun($sformatf("MISMATCH time=%0t signal=%s expected=%h actual=%h",
                         $time, sig, expv, actv));
   endtask

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycleLimit > 0 && cycles >= cycleLimit) begin
         abortRun($sformatf("timeout after %0d cycles without the core halting", cycles));
      end
   end

   function automatic logic [15:0] encR(input isaPkg::opcodeT op, input int rd,
                                        input int rs, input int rt);
      encR = {op, 3'(rd), 3'(rs), 3'(rt), 3'b000};
   endfunction

   function automatic logic [15:0] encI(input isaPkg::opcodeT op, input int rd,
                                        input int rs, input int imm);
      encI = {op, 3'(rd), 3'(rs), 6'(imm)};
   endfunction

   function automatic logic [15:0] encLbi(input int rd, input int imm);
      encLbi = {isaPkg::OpLbi, 3'(rd), 9'(imm)};
   endfunction

   task automatic addInstr(input int p, input logic [15:0] word);
      progWords[p][progLen[p]] = word;
      progLen[p]++;
   endtask

   // Instruction together with the register write it must produce
   task automatic addWriter(input int p, input logic [15:0] word, input int rd,
                            input logic [15:0] value);
      addInstr(p, word);
      expReg[p][expCount[p]] = 3'(rd);
      expData[p][expCount[p]] = value;
      expCount[p]++;
   endtask

   task automatic buildTable();
      // ALU operations on settled registers
      addWriter(0, encLbi(1, 5), 1, 16'h0005);
      addWriter(0, encLbi(2, -3), 2, 16'hfffd);
      addWriter(0, encLbi(3, 240), 3, 16'h00f0);
      addWriter(0, encLbi(4, 60), 4, 16'h003c);
      addWriter(0, encI(isaPkg::OpAddi, 6, 1, -7), 6, 16'hfffe);
      addWriter(0, encR(isaPkg::OpAdd, 5, 1, 2), 5, 16'h0002);
      addWriter(0, encR(isaPkg::OpSub, 7, 3, 4), 7, 16'h00b4);
      addWriter(0, encR(isaPkg::OpAnd, 5, 3, 4), 5, 16'h0030);
      addWriter(0, encR(isaPkg::OpXor, 7, 3, 4), 7, 16'h00cc);
      addInstr(0, 16'h0000);
      // Back-to-back dependencies
      addWriter(1, encLbi(1, 10), 1, 16'h000a);
      addWriter(1, encI(isaPkg::OpAddi, 2, 1, 3), 2, 16'h000d);
      addWriter(1, encR(isaPkg::OpAdd, 3, 2, 1), 3, 16'h0017);
      addWriter(1, encR(isaPkg::OpSub, 4, 3, 2), 4, 16'h000a);
      addWriter(1, encR(isaPkg::OpXor, 4, 4, 3), 4, 16'h001d);
      addWriter(1, encR(isaPkg::OpAnd, 5, 4, 4), 5, 16'h001d);
      addInstr(1, 16'h0000);
      // Stores and loads that overwrite mem[4] through a negative offset
      addWriter(2, encLbi(1, 85), 1, 16'h0055);
      addWriter(2, encLbi(2, 4), 2, 16'h0004);
      addWriter(2, encLbi(3, -1), 3, 16'hffff);
      addInstr(2, encI(isaPkg::OpSt, 1, 2, 0));
      addInstr(2, encI(isaPkg::OpSt, 3, 2, 1));
      addWriter(2, encI(isaPkg::OpLd, 4, 2, 0), 4, 16'h0055);
      addWriter(2, encI(isaPkg::OpLd, 5, 2, 1), 5, 16'hffff);
      addWriter(2, encI(isaPkg::OpAddi, 6, 2, 2), 6, 16'h0006);
      addInstr(2, encI(isaPkg::OpSt, 5, 6, -2));
      addWriter(2, encI(isaPkg::OpLd, 7, 2, 0), 7, 16'hffff);
      addInstr(2, 16'h0000);
      // One branch falls through and one is taken over a HALT in its shadow
      addWriter(3, encLbi(1, 0), 1, 16'h0000);
      addWriter(3, encLbi(2, 7), 2, 16'h0007);
      addInstr(3, encI(isaPkg::OpBeqz, 0, 2, 3));
      addWriter(3, encLbi(3, 1), 3, 16'h0001);
      addInstr(3, encI(isaPkg::OpBeqz, 0, 1, 3));
      addInstr(3, 16'h0000);
      addInstr(3, encLbi(5, 34));
      addInstr(3, encLbi(6, 51));
      addWriter(3, encLbi(7, 68), 7, 16'h0044);
      addInstr(3, 16'h0000);
      // Illegal opcode
      addWriter(4, encLbi(1, 9), 1, 16'h0009);
      addInstr(4, 16'ha000);
      addInstr(4, encLbi(2, 1));
      addInstr(4, 16'h0000);
      expErr[4] = 1'b1;
   endtask

   task automatic loadRom(input int p);
      for (int i = 0; i < RomDepth; i++) begin
         if (i < progLen[p]) begin
            rom[i] = progWords[p][i];
         end else begin
            rom[i] = {isaPkg::OpHalt, 12'($urandom)};
         end
      end
   endtask

   initial begin
      int evIdx;
      arstN = 1'b0;
      cycles = 0;
      cycleLimit = 0;
      for (int i = 0; i < RomDepth; i++) begin
         rom[i] = '0;
      end
      void'($urandom(Seed));
      buildTable();
      for (int p = 0; p < NumProgs; p++) begin
         cycleLimit += 12 * progLen[p] + 20;
      end

      for (int p = 0; p < NumProgs; p++) begin
         arstN = 1'b0;
         loadRom(p);
         repeat (3) @(negedge clk);
         assert (instrAddr == '0) else reportMismatch("instrAddr", 16'h0, instrAddr);
         assert (!wbEn) else reportMismatch("wbEn", 16'h0, 16'(wbEn));
         assert (!halted) else reportMismatch("halted", 16'h0, 16'(halted));
         assert (!err) else reportMismatch("err", 16'h0, 16'(err));
         arstN = 1'b1;

         evIdx = 0;
         while (!halted) begin
            @(negedge clk);
            if (wbEn) begin
               assert (evIdx < expCount[p])
                  else abortRun($sformatf("program %0d wrote more registers than expected", p));
               assert (wbReg == expReg[p][evIdx])
                  else reportMismatch("wbReg", 16'(expReg[p][evIdx]), 16'(wbReg));
               assert (wbData == expData[p][evIdx])
                  else reportMismatch("wbData", expData[p][evIdx], wbData);
               evIdx++;
            end
         end
         // Nothing may retire after the stop
         repeat (4) begin
            @(negedge clk);
            assert (!wbEn) else abortRun("a register was written after the core halted");
         end
         assert (evIdx == expCount[p])
            else reportMismatch("write count", 16'(expCount[p]), 16'(evIdx));
         assert (err == expErr[p]) else reportMismatch("err", 16'(expErr[p]), 16'(err));
      end

      $display("ALL TESTS PASSED");
      $finish;
   end

endmodule

`default_nettype wire

/* build.f */
common/isaPkg.sv
common/pipePkg.sv
rtl/pipeReg.sv
proc/fetch.sv
proc/decode.sv
proc/regFile.sv
proc/execute.sv
proc/dataMem.sv
proc/proc.sv
tests/proc_assertions.sv
tests/procTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= procTb
BUILD_DIR ?= build
FILELIST ?= build.f
VFLAGS ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# The simulator's exit status is the verdict
run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
